// ==== Makefile ====
# Verilator flow for the accelerator testbench.
VERILATOR ?= verilator
TOP       ?= accel_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS) common/accel_defines.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(EXE) | tee $(LOG)
	@grep -q '^sim passed$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)."; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/accel_defines.svh ====
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// Width of one stream word and of the job key, in bits.
`define ACCEL_DATA_W  32

// Register words seen through the peripheral port.
`define ACCEL_N_REGS  4

// One round per engine stage, so this is also the engine latency.
`define ACCEL_ROUNDS  4

`define ACCEL_CREDITS 4   // Input buffer depth and initial output credits.

`define ACCEL_CNT_W   16  // Width of the length and job counters.

`endif

// ==== common/accel_pkg.sv ====
`include "accel_defines.svh"

package accel_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Basic vector types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [`ACCEL_DATA_W-1:0]          data_t;     // Stream word or key.
  typedef logic [$clog2(`ACCEL_N_REGS)-1:0]  reg_addr_t; // Register word index.
  typedef logic [`ACCEL_CNT_W-1:0]           count_t;    // Word and job counts.

  // Main job FSM states.
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ctrl_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Peripheral port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic      req;
    logic      wen;    // High for a write, low for a read.
    reg_addr_t addr;
    data_t     wdata;
  } periph_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } periph_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control and flag structs.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic   busy;      // FSM is in RUN.
    logic   job_done;  // FSM is in DONE.
    count_t job_count; // Completed jobs since reset.
  } ctrl_slave_t;

  typedef struct packed {
    logic   start;     // Accepted trigger write.
    data_t  key;
    count_t length;
  } flags_slave_t;

  typedef struct packed {
    logic   enable;
    logic   start;     // One cycle, loads the job length.
    count_t length;
  } ctrl_streamer_t;

  typedef struct packed {
    logic done;        // Last result of the job has left the engine.
  } flags_streamer_t;

  typedef struct packed {
    data_t key;
  } ctrl_engine_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } engine_in_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } engine_out_t;

endpackage

// ==== ctrl/accel_ctrl.sv ====
`timescale 1ns/1ps

module accel_ctrl import accel_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  periph_req_t     periph_req_i,
  output periph_rsp_t     periph_rsp_o,
  output ctrl_streamer_t  ctrl_streamer_o,
  input  flags_streamer_t flags_streamer_i,
  output ctrl_engine_t    ctrl_engine_o,
  output logic            evt_o
);

  ctrl_slave_t  slave_ctrl;   // FSM to register file.
  flags_slave_t slave_flags;  // Register file to FSM.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register slave.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  accel_regfile i_regfile (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .ctrl_i       ( slave_ctrl   ),
    .flags_o      ( slave_flags  )
  );

  // Main FSM.
  accel_fsm i_fsm (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .slave_flags_i    ( slave_flags      ),
    .slave_ctrl_o     ( slave_ctrl       ),
    .ctrl_streamer_o  ( ctrl_streamer_o  ),
    .flags_streamer_i ( flags_streamer_i ),
    .ctrl_engine_o    ( ctrl_engine_o    ),
    .evt_o            ( evt_o            )
  );

endmodule

// ==== ctrl/accel_fsm.sv ====
`timescale 1ns/1ps

module accel_fsm import accel_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  flags_slave_t    slave_flags_i,
  output ctrl_slave_t     slave_ctrl_o,
  output ctrl_streamer_t  ctrl_streamer_o,
  input  flags_streamer_t flags_streamer_i,
  output ctrl_engine_t    ctrl_engine_o,
  output logic            evt_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  data_t       key_q;     // Key of the running job.
  count_t      length_q;  // Length of the running job.
  logic        start_q;   // Streamer start, high in the first RUN cycle.
  count_t      jobs_q;    // Completed job counter.

  // Next state logic.
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (slave_flags_i.start) state_d = RUN;
      RUN:     if (flags_streamer_i.done) state_d = DONE;
      DONE:    state_d = IDLE; // Single cycle, carries the event.
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      start_q <= 1'b0;
      jobs_q  <= '0;
    end else begin
      state_q <= state_d;
      start_q <= (state_q == IDLE) & slave_flags_i.start;
      if (state_q == DONE) jobs_q <= jobs_q + 1'b1;
    end
  end

  // Job parameters are frozen at the trigger so that register writes
  // during a job do not disturb it.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      key_q    <= '0;
      length_q <= '0;
    end else if (state_q == IDLE && slave_flags_i.start) begin
      key_q    <= slave_flags_i.key;
      length_q <= slave_flags_i.length;
    end
  end

  assign slave_ctrl_o.busy      = (state_q == RUN);
  assign slave_ctrl_o.job_done  = (state_q == DONE);
  assign slave_ctrl_o.job_count = jobs_q;

  assign ctrl_streamer_o.enable = (state_q == RUN);
  assign ctrl_streamer_o.start  = start_q;
  assign ctrl_streamer_o.length = length_q;

  assign ctrl_engine_o.key = key_q;

  assign evt_o = (state_q == DONE); // One cycle after the streamer's done.

endmodule

// ==== ctrl/accel_regfile.sv ====
`timescale 1ns/1ps
`include "accel_defines.svh"

module accel_regfile import accel_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  periph_req_t  periph_req_i,
  output periph_rsp_t  periph_rsp_o,
  input  ctrl_slave_t  ctrl_i,
  output flags_slave_t flags_o
);

  // Register word map.
  localparam reg_addr_t REG_TRIGGER = reg_addr_t'(0);
  localparam reg_addr_t REG_STATUS  = reg_addr_t'(1);
  localparam reg_addr_t REG_KEY     = reg_addr_t'(2);
  localparam reg_addr_t REG_LENGTH  = reg_addr_t'(3);

  data_t  key_q;      // KEY register.
  count_t length_q;   // LENGTH register.
  logic   rvalid_q;
  data_t  rdata_q;
  data_t  status;     // Live STATUS word.
  data_t  rdata_d;
  logic   wr_acc;     // Write accepted this cycle.
  logic   job_active; // A job is running or finishing.

  assign wr_acc     = periph_req_i.req & periph_req_i.wen;
  assign job_active = ctrl_i.busy | ctrl_i.job_done; // DONE still counts as busy.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // STATUS and read mux.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    status                      = '0;
    status[`ACCEL_DATA_W-1]     = job_active;       // Busy flag in the top bit.
    status[`ACCEL_CNT_W-1:0]    = ctrl_i.job_count; // Job count in the low half.
  end

  always_comb begin
    case (periph_req_i.addr)
      REG_STATUS: rdata_d = status;
      REG_KEY:    rdata_d = key_q;
      REG_LENGTH: rdata_d = data_t'(length_q);
      default:    rdata_d = '0; // TRIGGER reads back as zero.
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      key_q    <= '0;
      length_q <= '0;
    end else if (wr_acc) begin
      if (periph_req_i.addr == REG_KEY) key_q <= periph_req_i.wdata;
      if (periph_req_i.addr == REG_LENGTH) begin
        length_q <= periph_req_i.wdata[`ACCEL_CNT_W-1:0]; // Upper bits dropped.
      end
    end
  end

  // Read response comes one cycle after the request.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= periph_req_i.req & ~periph_req_i.wen;
  end

  always_ff @(posedge clk_i) begin
    if (periph_req_i.req && !periph_req_i.wen) rdata_q <= rdata_d;
  end

  assign periph_rsp_o.gnt    = periph_req_i.req; // Always ready, granted at once.
  assign periph_rsp_o.rvalid = rvalid_q;
  assign periph_rsp_o.rdata  = rdata_q;

  // A trigger while a job is active is dropped here.
  assign flags_o.start  = wr_acc & (periph_req_i.addr == REG_TRIGGER) & ~job_active;
  assign flags_o.key    = key_q;
  assign flags_o.length = length_q;

endmodule

// ==== sim.f ====
+incdir+common
common/accel_pkg.sv
ctrl/accel_regfile.sv
ctrl/accel_fsm.sv
ctrl/accel_ctrl.sv
verilog/accel_streamer.sv
verilog/accel_engine.sv
verilog/accel_top.sv
tests/accel_assertions.sv
tests/accel_tb.sv

// ==== tests/accel_assertions.sv ====
`timescale 1ns/1ps
`include "accel_defines.svh"

// Credit and valid invariants that are bound into accel_streamer.
module accel_assertions (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic                                 in_valid_i,   // Producer write.
  input logic                                 in_credit_i,  // Credit pulse back to producer.
  input logic                                 issue_i,      // Word leaves the buffer.
  input logic [$clog2(`ACCEL_CREDITS+1)-1:0]  fifo_cnt_i,   // Words held in the buffer.
  input logic [$clog2(`ACCEL_CREDITS+1)-1:0]  out_cred_i    // Output credits held.
);

  logic [$clog2(`ACCEL_CREDITS+1)-1:0] held_q; // Words written and not yet credited back.

  // Shadow count kept from the producer side of the input stream.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      held_q <= '0;
    end else if (in_valid_i && !in_credit_i) begin
      held_q <= held_q + 1'b1;
    end else if (!in_valid_i && in_credit_i) begin
      held_q <= held_q - 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output credit counter.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  cred_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_cred_i <= `ACCEL_CREDITS)
    else $error("Output credit count is above the credit depth.");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input buffer.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  fifo_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fifo_cnt_i < `ACCEL_CREDITS) || !in_valid_i || issue_i)
    else $error("Input buffer written while full.");

  // A credit goes back only for a word that the producer wrote earlier.
  in_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_credit_i |-> (held_q != '0))
    else $error("Input credit returned with no word in the buffer.");

endmodule

// ==== tests/accel_tb.sv ====
`timescale 1ns/1ps
`include "accel_defines.svh"

module accel_tb import accel_pkg::*; ();

  localparam reg_addr_t ADDR_TRIGGER = reg_addr_t'(0);
  localparam reg_addr_t ADDR_STATUS  = reg_addr_t'(1);
  localparam reg_addr_t ADDR_KEY     = reg_addr_t'(2);
  localparam reg_addr_t ADDR_LENGTH  = reg_addr_t'(3);

  localparam int N_JOBS  = 6;   // Jobs in the whole test plus a margin.
  localparam int MAX_LEN = 16;  // Longest random job.
  localparam int MAX_GAP = 7;   // Longest pause before a credit return.
  // Every word may wait a full credit gap, plus register traffic per job.
  localparam int MAX_CYCLES = N_JOBS * (MAX_LEN * (MAX_GAP + 3) + 60) + 100;

  logic        clk_i;
  logic        rst_n_i;
  periph_req_t periph_req;
  periph_rsp_t periph_rsp;
  logic        in_valid_i;
  data_t       in_data_i;
  logic        in_credit_o;
  logic        out_valid_o;
  data_t       out_data_o;
  logic        out_credit_i;
  logic        evt_o;

  logic [31:0] rng_q;          // Xorshift state.
  int          cycle_cnt = 0;
  int          test_errs = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          jobs_done = 0;  // Completed jobs the model expects.
  data_t       exp_q [$];      // Model results with the oldest first.
  data_t       job_key;
  int          job_len;
  int          sent;
  int          rcv;
  int          evt_cnt;
  int          evt_step;
  int          job_steps;
  int          prod_credits;   // Credits the producer holds.
  int          cons_credits;   // Free slots the consumer has granted.
  int          cons_held;      // Words the consumer still has to free.
  int          cons_wait;      // Cycles before the next credit return.

  accel_top DUT (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .periph_req_i ( periph_req   ),
    .periph_rsp_o ( periph_rsp   ),
    .in_valid_i   ( in_valid_i   ),
    .in_data_i    ( in_data_i    ),
    .in_credit_o  ( in_credit_o  ),
    .out_valid_o  ( out_valid_o  ),
    .out_data_o   ( out_data_o   ),
    .out_credit_i ( out_credit_i ),
    .evt_o        ( evt_o        )
  );

  bind accel_streamer accel_assertions u_assertions (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_credit_i ( in_credit_o ),
    .issue_i     ( issue       ),
    .fifo_cnt_i  ( fifo_cnt_q  ),
    .out_cred_i  ( out_cred_q  )
  );

  always #10 clk_i = ~clk_i; // 20 ns period.

  // Run limit, sized from the job lengths above.
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a job never completed.", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Model and helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  // Each round XORs the key in and rotates the word left by one byte.
  function automatic data_t ref_encrypt(data_t d, data_t k);
    data_t x;
    for (int r = 0; r < `ACCEL_ROUNDS; r++) begin
      x = d ^ k;
      d = (x << 8) | (x >> (`ACCEL_DATA_W - 8));
    end
    return d;
  endfunction

  task automatic value_error(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    test_errs++;
  endtask

  task automatic plain_error(input string msg);
    $display("At %0d ns, %s", $time, msg);
    test_errs++;
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      $display("Test %s: ok.", name);
      pass_cnt++;
    end else begin
      $display("Test %s: %0d errors.", name, test_errs);
      fail_cnt++;
    end
    test_errs = 0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Peripheral port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic reg_write(input reg_addr_t addr, input data_t val);
    @(negedge clk_i);
    periph_req = '{req: 1'b1, wen: 1'b1, addr: addr, wdata: val};
    @(posedge clk_i);
    if (!periph_rsp.gnt) plain_error("a register write was not granted.");
    @(negedge clk_i);
    periph_req = '0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output data_t val);
    @(negedge clk_i);
    periph_req = '{req: 1'b1, wen: 1'b0, addr: addr, wdata: '0};
    @(posedge clk_i);
    if (!periph_rsp.gnt) plain_error("a register read was not granted.");
    @(negedge clk_i);
    periph_req = '0;
    if (!periph_rsp.rvalid) plain_error("a register read gave no rvalid one cycle later.");
    val = periph_rsp.rdata; // Read data sits with rvalid.
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One cycle of producer, consumer and monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step_cycle(input bit bp, input bit dense);
    logic        credit_back;
    data_t       exp_word;
    logic [31:0] coin;
    @(negedge clk_i);
    job_steps++;
    credit_back = in_credit_o; // Driven from registered state and stable at the falling edge.
    if (out_valid_o) begin
      if (exp_q.size() == 0) begin
        plain_error("an output word came out that no input word accounts for.");
      end else begin
        exp_word = exp_q.pop_front();
        if (out_data_o !== exp_word) begin
          value_error($sformatf("word %0d is %h, expected %h", rcv, out_data_o, exp_word));
        end
      end
      if (cons_credits == 0) plain_error("a word arrived without a free output slot.");
      else cons_credits--;
      cons_held++;
      rcv++;
    end
    if (evt_o) begin
      evt_cnt++;
      if (evt_cnt == 1) evt_step = job_steps;
    end
    out_credit_i = 1'b0; // Consumer frees one slot per return.
    if (cons_held != 0) begin
      if (cons_wait == 0) begin
        out_credit_i = 1'b1;
        cons_held--;
        cons_credits++;
        cons_wait = bp ? int'(xorshift32() % (MAX_GAP + 1)) : 0;
      end else begin
        cons_wait--;
      end
    end
    coin = xorshift32();
    in_valid_i = 1'b0; // The producer sends only while it holds a credit.
    if (sent < job_len && prod_credits != 0 && (dense || coin[1:0] != 2'b00)) begin
      in_valid_i = 1'b1;
      in_data_i  = xorshift32();
      exp_q.push_back(ref_encrypt(in_data_i, job_key));
      prod_credits--;
      sent++;
    end
    if (credit_back) begin
      if (prod_credits >= `ACCEL_CREDITS) plain_error("an input credit came back unowed.");
      else prod_credits++;
    end
  endtask

  task automatic run_job(input int len, input bit bp, input bit dense, input bit poke);
    data_t st;
    job_len   = len;
    job_key   = xorshift32();
    sent      = 0;
    rcv       = 0;
    evt_cnt   = 0;
    evt_step  = 0;
    job_steps = 0;
    cons_wait = 0;
    reg_write(ADDR_KEY, job_key);
    reg_write(ADDR_LENGTH, data_t'(len));
    reg_write(ADDR_TRIGGER, '0);
    if (poke) begin
      // No input words yet, so the job cannot finish under these accesses.
      reg_read(ADDR_STATUS, st);
      if (st[`ACCEL_DATA_W-1] !== 1'b1) value_error("STATUS busy bit is low during a job");
      reg_write(ADDR_TRIGGER, '0);
    end
    while (!(evt_cnt != 0 && rcv == len && cons_held == 0)) step_cycle(bp, dense);
    repeat (6) step_cycle(bp, dense); // A quiet tail catches late events.
    if (evt_cnt != 1) plain_error($sformatf("evt_o pulsed %0d times for one job.", evt_cnt));
    if (exp_q.size() != 0) plain_error("some expected words never came out.");
    if (prod_credits != `ACCEL_CREDITS) plain_error("the producer did not regain all credits.");
    if (cons_credits != `ACCEL_CREDITS) plain_error("output slots were left in use.");
    jobs_done++;
    reg_read(ADDR_STATUS, st);
    if (st !== data_t'(jobs_done)) begin
      value_error($sformatf("STATUS is %h after the job, expected %h", st, jobs_done));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    data_t rd;
    data_t wr;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    periph_req   = '0;
    in_valid_i   = 1'b0;
    in_data_i    = '0;
    out_credit_i = 1'b0;
    rng_q        = 32'd78;
    prod_credits = `ACCEL_CREDITS;
    cons_credits = `ACCEL_CREDITS;
    cons_held    = 0;
    job_len      = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Register access and idle state after reset.
    if (in_credit_o || out_valid_o || evt_o || periph_rsp.rvalid) begin
      plain_error("an output was active right after reset.");
    end
    reg_read(ADDR_STATUS, rd);
    if (rd !== '0) value_error($sformatf("STATUS is %h after reset", rd));
    wr = xorshift32();
    reg_write(ADDR_KEY, wr);
    reg_read(ADDR_KEY, rd);
    if (rd !== wr) value_error($sformatf("KEY reads %h, wrote %h", rd, wr));
    wr = xorshift32() & 32'h0000_ffff; // LENGTH holds the low 16 bits.
    reg_write(ADDR_LENGTH, wr);
    reg_read(ADDR_LENGTH, rd);
    if (rd !== wr) value_error($sformatf("LENGTH reads %h, wrote %h", rd, wr));
    end_test("register_access");

    run_job(8 + int'(xorshift32() % 9), 1'b0, 1'b0, 1'b0);
    end_test("random_job");
    run_job(MAX_LEN, 1'b1, 1'b0, 1'b0); // Consumer pauses between returns.
    end_test("back_pressure");
    run_job(8 + int'(xorshift32() % 9), 1'b1, 1'b1, 1'b0); // Producer at full rate.
    end_test("input_credits");
    run_job(8 + int'(xorshift32() % 9), 1'b0, 1'b0, 1'b1);
    end_test("status_busy");
    run_job(0, 1'b0, 1'b0, 1'b0);
    if (evt_step != 1) plain_error("the zero length job did not finish 2 cycles after trigger.");
    if (rcv != 0) plain_error("the zero length job produced output words.");
    end_test("zero_length");

    $display("%0d tests ok, %0d tests with errors.", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog/accel_engine.sv ====
`timescale 1ns/1ps
`include "accel_defines.svh"

module accel_engine import accel_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  ctrl_engine_t ctrl_i,
  input  engine_in_t   engine_i,
  output engine_out_t  engine_o
);

  data_t                     stage_data_q [`ACCEL_ROUNDS]; // One word per stage.
  logic [`ACCEL_ROUNDS-1:0]  stage_vld_q;

  // One round: XOR with the key, then rotate left by one byte.
  function automatic data_t round_f(data_t d, data_t k);
    data_t x;
    x = d ^ k;
    return {x[`ACCEL_DATA_W-9:0], x[`ACCEL_DATA_W-1:`ACCEL_DATA_W-8]};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Round pipeline.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    stage_data_q[0] <= round_f(engine_i.data, ctrl_i.key);
    for (int i = 1; i < `ACCEL_ROUNDS; i++) begin
      stage_data_q[i] <= round_f(stage_data_q[i-1], ctrl_i.key);
    end
  end

  // Valid bits travel alongside; the pipeline never stalls.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_vld_q <= '0;
    end else begin
      stage_vld_q <= {stage_vld_q[`ACCEL_ROUNDS-2:0], engine_i.valid};
    end
  end

  assign engine_o.valid = stage_vld_q[`ACCEL_ROUNDS-1];
  assign engine_o.data  = stage_data_q[`ACCEL_ROUNDS-1]; // Last stage is the output.

endmodule

// ==== verilog/accel_streamer.sv ====
`timescale 1ns/1ps
`include "accel_defines.svh"

module accel_streamer import accel_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  input  data_t           in_data_i,
  output logic            in_credit_o,
  input  logic            out_credit_i,
  input  ctrl_streamer_t  ctrl_i,
  output flags_streamer_t flags_o,
  output engine_in_t      engine_o,
  input  logic            engine_valid_i
);

  localparam int unsigned PTR_W = $clog2(`ACCEL_CREDITS);
  localparam int unsigned CRD_W = $clog2(`ACCEL_CREDITS + 1);

  data_t              fifo_q [`ACCEL_CREDITS]; // Input buffer storage.
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CRD_W-1:0]   fifo_cnt_q;   // Words held in the buffer.
  logic [CRD_W-1:0]   out_cred_q;   // Free slots downstream.
  count_t             iss_left_q;   // Words still to issue.
  count_t             res_left_q;   // Results still to come out.
  logic               run_q;        // Job with at least one word in progress.
  logic               issue;
  logic               last_res;

  // One word per cycle, only with a buffered word and a reserved credit.
  assign issue = ctrl_i.enable & run_q & (fifo_cnt_q != '0) &
                 (out_cred_q != '0) & (iss_left_q != '0);

  assign last_res = run_q & engine_valid_i & (res_left_q == count_t'(1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input buffer.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (in_valid_i) fifo_q[wr_ptr_q] <= in_data_i; // Space guaranteed by credits.
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (in_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`ACCEL_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (issue) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`ACCEL_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (in_valid_i && !issue)      fifo_cnt_q <= fifo_cnt_q + 1'b1;
      else if (!in_valid_i && issue) fifo_cnt_q <= fifo_cnt_q - 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output credits and job counters.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_cred_q <= CRD_W'(`ACCEL_CREDITS); // Consumer starts with empty slots.
    end else if (issue && !out_credit_i) begin
      out_cred_q <= out_cred_q - 1'b1;     // Credit taken at issue.
    end else if (!issue && out_credit_i) begin
      out_cred_q <= out_cred_q + 1'b1;     // Consumer freed a slot.
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      iss_left_q <= '0;
      res_left_q <= '0;
      run_q      <= 1'b0;
    end else if (ctrl_i.start) begin
      iss_left_q <= ctrl_i.length;
      res_left_q <= ctrl_i.length;
      run_q      <= (ctrl_i.length != '0); // Empty job never runs.
    end else begin
      if (issue) iss_left_q <= iss_left_q - 1'b1;
      if (run_q && engine_valid_i) res_left_q <= res_left_q - 1'b1;
      if (last_res) run_q <= 1'b0;
    end
  end

  assign in_credit_o   = issue; // Slot freed as the word leaves.
  assign engine_o.valid = issue;
  assign engine_o.data  = fifo_q[rd_ptr_q];

  // A zero length job finishes in its start cycle.
  assign flags_o.done = (ctrl_i.start & (ctrl_i.length == '0)) | last_res;

endmodule

// ==== verilog/accel_top.sv ====
`timescale 1ns/1ps

module accel_top import accel_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  periph_req_t periph_req_i,
  output periph_rsp_t periph_rsp_o,
  input  logic        in_valid_i,
  input  data_t       in_data_i,
  output logic        in_credit_o,
  output logic        out_valid_o,
  output data_t       out_data_o,
  input  logic        out_credit_i,
  output logic        evt_o
);

  ctrl_streamer_t  ctrl_streamer;
  flags_streamer_t flags_streamer;
  ctrl_engine_t    ctrl_engine;
  engine_in_t      engine_in;
  engine_out_t     engine_out;

  accel_ctrl i_ctrl (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .periph_req_i     ( periph_req_i   ),
    .periph_rsp_o     ( periph_rsp_o   ),
    .ctrl_streamer_o  ( ctrl_streamer  ),
    .flags_streamer_i ( flags_streamer ),
    .ctrl_engine_o    ( ctrl_engine    ),
    .evt_o            ( evt_o          )
  );

  accel_streamer i_streamer (
    .clk_i          ( clk_i            ),
    .rst_n_i        ( rst_n_i          ),
    .in_valid_i     ( in_valid_i       ),
    .in_data_i      ( in_data_i        ),
    .in_credit_o    ( in_credit_o      ),
    .out_credit_i   ( out_credit_i     ),
    .ctrl_i         ( ctrl_streamer    ),
    .flags_o        ( flags_streamer   ),
    .engine_o       ( engine_in        ),
    .engine_valid_i ( engine_out.valid ) // Results counted as they leave.
  );

  accel_engine i_engine (
    .clk_i    ( clk_i       ),
    .rst_n_i  ( rst_n_i     ),
    .ctrl_i   ( ctrl_engine ),
    .engine_i ( engine_in   ),
    .engine_o ( engine_out  )
  );

  assign out_valid_o = engine_out.valid;
  assign out_data_o  = engine_out.data;

endmodule
